// ==== all.f ====
+incdir+tb
hdl/heapPkg.sv
hdl/heapCommandDecoder.sv
hdl/heapCommandQueue.sv
hdl/heapArrayEngine.sv
hdl/heapMemory.sv
tb/tbHeapMemory.sv

// ==== tb/heapModel.svh ====
// Heap reference model for the testbench
// Own arrays, size table and free list, plus the Galois LFSR for stimulus

`ifndef HEAP_MODEL_SVH
`define HEAP_MODEL_SVH

//------------------------------------------------------------
// Model state
//------------------------------------------------------------
dataT        modelElements [ARRAY_COUNT][ARRAY_LENGTH];
int          modelSize     [ARRAY_COUNT];           // Elements in use
bit          modelAlloc    [ARRAY_COUNT];           // Handed out, not freed
bit          modelUsed     [ARRAY_COUNT];           // Handed out at least once
int          modelNextNew;                          // First never-used array
int          modelFree     [$];                     // Freed arrays, newest at back
logic [15:0] lfsrState;

function automatic void clearModel();
  for (int a = 0; a < ARRAY_COUNT; a++) begin
    modelSize[a]  = 0;
    modelAlloc[a] = 1'b0;
    modelUsed[a]  = 1'b0;
    for (int i = 0; i < ARRAY_LENGTH; i++) begin
      modelElements[a][i] = '0;
    end
  end
  modelNextNew = 0;
  modelFree.delete();
endfunction

// Allocation checks, then the bounds check when an index is used
function automatic errorT accessError(input int a, input int i, input bit indexed);
  if (!modelUsed[a]) return errNotAllocated;
  if (!modelAlloc[a]) return errFreed;
  if (indexed && i >= modelSize[a]) return errOutOfBounds;
  return errNone;
endfunction

//------------------------------------------------------------
// One command applied to the model
//------------------------------------------------------------
function automatic responseT predictResponse(input commandT cmd);
  responseT rsp;
  int       a;
  int       i;
  int       picked;
  a      = int'(cmd.array);
  i      = int'(cmd.index);
  picked = -1;
  rsp    = '{data: '0, error: errNone};
  case (cmd.action)
    ACTION_WRITE: begin
      rsp.error = accessError(a, i, 1'b0);
      if (rsp.error == errNone) begin
        modelElements[a][i] = cmd.data;
        if (i + 1 > modelSize[a]) modelSize[a] = i + 1;   // Grow to cover index
        rsp.data = cmd.data;
      end
    end
    ACTION_READ: begin
      rsp.error = accessError(a, i, 1'b1);
      if (rsp.error == errNone) rsp.data = modelElements[a][i];
    end
    ACTION_SIZE: begin
      rsp.error = accessError(a, i, 1'b0);
      if (rsp.error == errNone) rsp.data = dataT'(modelSize[a]);
    end
    ACTION_PUSH: begin
      rsp.error = accessError(a, i, 1'b0);
      if (rsp.error == errNone && modelSize[a] == ARRAY_LENGTH) begin
        rsp.error = errFull;
      end else if (rsp.error == errNone) begin
        modelElements[a][modelSize[a]] = cmd.data;
        modelSize[a]++;
      end
    end
    ACTION_POP: begin
      rsp.error = accessError(a, i, 1'b0);
      if (rsp.error == errNone && modelSize[a] == 0) begin
        rsp.error = errEmpty;
      end else if (rsp.error == errNone) begin
        modelSize[a]--;
        rsp.data = modelElements[a][modelSize[a]];        // Removed element
      end
    end
    ACTION_ADD: begin
      rsp.error = accessError(a, i, 1'b1);
      if (rsp.error == errNone) begin
        modelElements[a][i] = modelElements[a][i] + cmd.data;  // Wraps at 12 bits
        rsp.data = modelElements[a][i];
      end
    end
    ACTION_ALLOC: begin
      if (modelFree.size() > 0) begin
        picked = modelFree.pop_back();                   // Latest freed first
      end else if (modelNextNew < ARRAY_COUNT) begin
        picked = modelNextNew;
        modelNextNew++;
      end
      if (picked < 0) begin
        rsp.error = errOutOfMemory;
      end else begin
        modelAlloc[picked] = 1'b1;
        modelUsed[picked]  = 1'b1;
        modelSize[picked]  = 0;
        rsp.data = dataT'(picked);
      end
    end
    ACTION_FREE: begin
      rsp.error = accessError(a, i, 1'b0);
      if (rsp.error == errNone) begin
        modelAlloc[a] = 1'b0;
        modelFree.push_back(a);
      end
    end
    default: begin
      rsp.error = errUnknownAction;
    end
  endcase
  return rsp;
endfunction

// 16-bit Galois LFSR, one step per bit taken
function automatic logic [31:0] randomBits(input int count);
  logic [31:0] value;
  value = '0;
  for (int n = 0; n < count; n++) begin
    lfsrState = {1'b0, lfsrState[15:1]} ^ (lfsrState[0] ? 16'hB400 : 16'h0000);
    value     = {value[30:0], lfsrState[0]};
  end
  return value;
endfunction

`endif

// ==== tb/tbHeapMemory.sv ====
// Heap memory testbench
// Drives both four-phase handshakes, checks each response against the model

`timescale 1ns/1ps

module tbHeapMemory;

  import heapPkg::*;

  localparam int WAIT_LIMIT   = 400;                // Cycles before a wait gives up
  localparam int RANDOM_COUNT = 300;
  localparam int STALL_COUNT  = 40;

  logic     clock;
  logic     resetN;
  logic     cmdReq;
  commandT  command;
  logic     cmdAck;
  logic     rspReq;
  responseT response;
  logic     rspAck;

  responseT expected [$];                           // Predicted responses, oldest first
  commandT  streamCmds [$];
  int       streamHolds [$];                        // rspAck delay per response
  int       errorCount;
  int       checkCount;

  `include "heapModel.svh"

  heapMemory u_heapMemory (
    .clock    (clock),
    .resetN   (resetN),
    .cmdReq   (cmdReq),
    .command  (command),
    .cmdAck   (cmdAck),
    .rspReq   (rspReq),
    .response (response),
    .rspAck   (rspAck)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;                      // 10 ns period
  end

  //------------------------------------------------------------
  // Checks and handshakes
  //------------------------------------------------------------
  task automatic abortRun(input string why);
    $display("Run stopped: %s", why);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  task automatic compareData(input string name, input dataT actual, input dataT wanted);
    checkCount++;
    if (actual !== wanted) begin
      errorCount++;
      $display("ERROR %s: got 0x%h, expected 0x%h", name, actual, wanted);
    end
  endtask

  task automatic compareError(input string name, input errorT actual, input errorT wanted);
    checkCount++;
    if (actual !== wanted) begin
      errorCount++;
      $display("ERROR %s: got 0x%h, expected 0x%h", name, actual, wanted);
    end
  endtask

  task automatic sendCommand(input commandT cmd);
    int waited;
    expected.push_back(predictResponse(cmd));       // Heap runs commands in order
    @(posedge clock);
    command <= cmd;
    cmdReq  <= 1'b1;
    waited = 0;
    do begin
      @(posedge clock);
      waited++;
    end while (!cmdAck && waited < WAIT_LIMIT);
    if (!cmdAck) begin
      abortRun("cmdAck never rose for a command");
    end else begin
      cmdReq <= 1'b0;
      waited = 0;
      do begin
        @(posedge clock);
        waited++;
      end while (cmdAck && waited < WAIT_LIMIT);
      if (cmdAck) abortRun("cmdAck stayed high after cmdReq fell");
    end
  endtask

  task automatic takeResponse(input int hold, output responseT got);
    int       waited;
    responseT wanted;
    waited = 0;
    do begin
      @(posedge clock);
      waited++;
    end while (!rspReq && waited < WAIT_LIMIT);
    if (!rspReq) begin
      abortRun("rspReq never rose for an expected response");
    end else begin
      got = response;                               // Held while rspReq is high
      repeat (hold) @(posedge clock);               // Receiver stall
      rspAck <= 1'b1;
      waited = 0;
      do begin
        @(posedge clock);
        waited++;
      end while (rspReq && waited < WAIT_LIMIT);
      if (rspReq) begin
        abortRun("rspReq stayed high after rspAck rose");
      end else begin
        rspAck <= 1'b0;
        if (expected.size() == 0) begin
          errorCount++;
          $display("Response arrived with no command outstanding");
        end else begin
          wanted = expected.pop_front();
          compareData("response.data", got.data, wanted.data);
          compareError("response.error", got.error, wanted.error);
        end
      end
    end
  endtask

  // One command and its response, with the value the test expects
  task automatic runCommand(input logic [7:0] action, input int array, input int index,
                            input int data, input dataT wantData, input errorT wantError);
    commandT  cmd;
    responseT got;
    cmd.action = action;
    cmd.array  = arrayNumT'(array);
    cmd.index  = indexT'(index);
    cmd.data   = dataT'(data);
    sendCommand(cmd);
    takeResponse(0, got);
    compareData("response.data", got.data, wantData);
    compareError("response.error", got.error, wantError);
  endtask

  function automatic logic [7:0] actionFor(input int sel);
    case (sel)
      0:       return ACTION_WRITE;
      1:       return ACTION_READ;
      2:       return ACTION_SIZE;
      3:       return ACTION_PUSH;
      4:       return ACTION_POP;
      5:       return ACTION_ALLOC;
      6:       return ACTION_FREE;
      default: return ACTION_ADD;
    endcase
  endfunction

  // Random commands sent and taken side by side, stimulus drawn up front
  task automatic runStream(input int count, input bit longStall);
    commandT  cmd;
    responseT got;
    int       sel;
    streamCmds.delete();
    streamHolds.delete();
    for (int n = 0; n < count; n++) begin
      sel = int'(randomBits(4));
      if (sel < 14) cmd.action = actionFor(sel % 8);
      else          cmd.action = 8'(randomBits(8)); // Mostly unknown bytes
      cmd.array = arrayNumT'(randomBits(ADDRESS_BITS));
      cmd.index = indexT'(randomBits(INDEX_BITS));
      cmd.data  = dataT'(randomBits(DATA_BITS));
      streamCmds.push_back(cmd);
      if (longStall) streamHolds.push_back(16 + int'(randomBits(5)));
      else           streamHolds.push_back(int'(randomBits(1)));
    end
    fork
      begin
        foreach (streamCmds[n]) sendCommand(streamCmds[n]);
      end
      begin
        foreach (streamHolds[n]) takeResponse(streamHolds[n], got);
      end
    join
  endtask

  task automatic reportTest(input int number, input string name,
                            input int firstCheck, input int firstError);
    $display("Test %0d %s: %0d checks, %0d errors", number, name,
             checkCount - firstCheck, errorCount - firstError);
  endtask

  //------------------------------------------------------------
  // Test sequence
  //------------------------------------------------------------
  initial begin
    int   markChecks;
    int   markErrors;
    dataT value;
    resetN     = 1'b0;
    cmdReq     = 1'b0;
    command    = '0;
    rspAck     = 1'b0;
    errorCount = 0;
    checkCount = 0;
    lfsrState  = 16'd66;
    clearModel();
    repeat (3) @(posedge clock);
    resetN <= 1'b1;
    @(posedge clock);

    markChecks = checkCount;
    markErrors = errorCount;
    for (int n = 0; n < ARRAY_COUNT; n++) begin
      runCommand(ACTION_ALLOC, 0, 0, 0, dataT'(n), errNone);
    end
    runCommand(ACTION_ALLOC, 0, 0, 0, '0, errOutOfMemory);
    reportTest(1, "alloc order", markChecks, markErrors);

    markChecks = checkCount;
    markErrors = errorCount;
    runCommand(ACTION_PUSH, 0, 0, 1, '0, errNone);
    runCommand(ACTION_PUSH, 0, 0, 2, '0, errNone);
    runCommand(ACTION_SIZE, 0, 0, 0, 12'd2, errNone);
    runCommand(ACTION_READ, 0, 0, 0, 12'd1, errNone);
    runCommand(ACTION_READ, 0, 1, 0, 12'd2, errNone);
    reportTest(2, "push size read", markChecks, markErrors);

    markChecks = checkCount;
    markErrors = errorCount;
    runCommand(ACTION_READ, 0, 2, 0, '0, errOutOfBounds);
    runCommand(ACTION_POP, 1, 0, 0, '0, errEmpty);
    for (int n = 0; n < ARRAY_LENGTH; n++) begin
      runCommand(ACTION_PUSH, 2, 0, 10 + n, '0, errNone);
    end
    runCommand(ACTION_PUSH, 2, 0, 99, '0, errFull);
    runCommand(8'd1, 0, 0, 0, '0, errUnknownAction);   // Old reset action
    reportTest(3, "access checks", markChecks, markErrors);

    markChecks = checkCount;
    markErrors = errorCount;
    runCommand(ACTION_FREE, 1, 0, 0, '0, errNone);
    runCommand(ACTION_FREE, 3, 0, 0, '0, errNone);
    runCommand(ACTION_READ, 3, 0, 0, '0, errFreed);
    runCommand(ACTION_PUSH, 3, 0, 7, '0, errFreed);
    runCommand(ACTION_FREE, 3, 0, 0, '0, errFreed);    // Double free refused
    runCommand(ACTION_ALLOC, 0, 0, 0, 12'd3, errNone);
    runCommand(ACTION_SIZE, 3, 0, 0, '0, errNone);
    runCommand(ACTION_ALLOC, 0, 0, 0, 12'd1, errNone);
    reportTest(4, "free and reuse", markChecks, markErrors);

    markChecks = checkCount;
    markErrors = errorCount;
    for (int a = 0; a < ARRAY_COUNT; a++) begin         // Every element gets a value
      for (int i = 0; i < ARRAY_LENGTH; i++) begin
        value = dataT'(randomBits(DATA_BITS));
        runCommand(ACTION_WRITE, a, i, int'(value), value, errNone);
      end
    end
    runStream(RANDOM_COUNT, 1'b0);
    reportTest(5, "random mix", markChecks, markErrors);

    markChecks = checkCount;
    markErrors = errorCount;
    runStream(STALL_COUNT, 1'b1);
    if (expected.size() != 0) begin
      errorCount++;
      $display("Commands left without a response: %0d", expected.size());
    end
    reportTest(6, "back-pressure", markChecks, markErrors);

    $display("Tests run: 6, checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== hdl/heapMemory.sv ====
// Heap memory top level
// Command decoder feeding a command queue, drained by the array engine

`timescale 1ns/1ps

module heapMemory (
  input  logic              clock,
  input  logic              resetN,
  input  logic              cmdReq,                 // Request handshake
  input  heapPkg::commandT  command,
  output logic              cmdAck,
  output logic              rspReq,                 // Response handshake
  output heapPkg::responseT response,
  input  logic              rspAck
);

  import heapPkg::*;

  logic    pushValid;                               // Decoder to queue
  requestT pushRequest;
  logic    queueFull;                               // Queue back-pressure
  logic    headValid;                               // Queue to engine
  requestT headRequest;
  logic    popTake;                                 // Engine takes head

  heapCommandDecoder u_heapCommandDecoder (
    .clock       (clock),
    .resetN      (resetN),
    .cmdReq      (cmdReq),
    .command     (command),
    .queueFull   (queueFull),
    .cmdAck      (cmdAck),
    .pushValid   (pushValid),
    .pushRequest (pushRequest)
  );

  heapCommandQueue u_heapCommandQueue (
    .clock       (clock),
    .resetN      (resetN),
    .pushValid   (pushValid),
    .pushRequest (pushRequest),
    .popTake     (popTake),
    .headValid   (headValid),
    .headRequest (headRequest),
    .queueFull   (queueFull)
  );

  heapArrayEngine u_heapArrayEngine (
    .clock       (clock),
    .resetN      (resetN),
    .headValid   (headValid),
    .headRequest (headRequest),
    .popTake     (popTake),
    .rspReq      (rspReq),
    .response    (response),
    .rspAck      (rspAck)
  );

endmodule

// ==== hdl/heapArrayEngine.sv ====
// Heap array engine
// Holds the arrays, size table and free list, runs one queued
// operation at a time and returns its result on the response handshake

`timescale 1ns/1ps

module heapArrayEngine (
  input  logic              clock,
  input  logic              resetN,
  input  logic              headValid,              // Queue has an entry
  input  heapPkg::requestT  headRequest,            // Entry to execute
  output logic              popTake,                // Remove head this cycle
  output logic              rspReq,                 // Response ready
  output heapPkg::responseT response,               // Data and error
  input  logic              rspAck                  // Receiver took it
);

  import heapPkg::*;

  typedef enum logic [1:0] {
    engIdle,                                        // Ready for next entry
    engWaitAck,                                     // rspReq high
    engWaitRelease                                  // Waiting for rspAck low
  } engStateT;

  engStateT                 engState;

  //------------------------------------------------------------
  // Heap state
  //------------------------------------------------------------
  dataT                     elements [ARRAY_COUNT][ARRAY_LENGTH];
  sizeT [ARRAY_COUNT-1:0]   sizes;                  // Current length per array
  logic [ARRAY_COUNT-1:0]   allocated;              // Handed out and not freed
  logic [ARRAY_COUNT-1:0]   everUsed;               // Handed out at least once
  logic [ADDRESS_BITS:0]    nextNew;                // Next never-used array
  arrayNumT                 freeList [ARRAY_COUNT]; // Freed arrays, stack
  logic [ADDRESS_BITS:0]    freeTop;                // Entries on the free list
  arrayNumT                 freeTopIdx;             // Slot of the top entry

  // Per-operation values
  arrayNumT  arr;
  indexT     idx;
  sizeT      curSize;
  dataT      elemValue;
  dataT      addSum;
  indexT     lastIdx;
  errorT     writeErr;
  errorT     readErr;

  // Decided effects of the head entry
  responseT  rspNext;
  logic      storeEn;
  indexT     storeIdx;
  dataT      storeData;
  logic      sizeEn;
  arrayNumT  sizeArray;
  sizeT      sizeNext;
  logic      allocEn;
  logic      allocFromList;
  arrayNumT  allocArray;
  logic      freeEn;

  assign arr        = headRequest.array;
  assign idx        = headRequest.index;
  assign curSize    = sizes[arr];
  assign elemValue  = elements[arr][idx];
  assign addSum     = elemValue + headRequest.data; // Wraps at DATA_BITS
  assign lastIdx    = indexT'(curSize - sizeT'(1));
  assign freeTopIdx = arrayNumT'(freeTop - 1'b1);

  // Writable then readable checks
  assign writeErr = !everUsed[arr]  ? errNotAllocated :
                    !allocated[arr] ? errFreed        : errNone;
  assign readErr  = (writeErr != errNone)     ? writeErr       :
                    (sizeT'(idx) >= curSize)  ? errOutOfBounds : errNone;

  //------------------------------------------------------------
  // Operation decode
  //------------------------------------------------------------
  always_comb begin
    rspNext       = '{data: '0, error: errNone};
    storeEn       = 1'b0;
    storeIdx      = idx;
    storeData     = headRequest.data;
    sizeEn        = 1'b0;
    sizeArray     = arr;
    sizeNext      = curSize;
    allocEn       = 1'b0;
    allocFromList = 1'b0;
    allocArray    = freeList[freeTopIdx];
    freeEn        = 1'b0;
    case (headRequest.opKind)
      opWrite: begin
        if (writeErr != errNone) begin
          rspNext.error = writeErr;
        end else begin
          storeEn      = 1'b1;
          rspNext.data = headRequest.data;
          if (sizeT'(idx) >= curSize) begin         // Grow to cover index
            sizeEn   = 1'b1;
            sizeNext = sizeT'(idx) + sizeT'(1);
          end
        end
      end
      opRead: begin
        if (readErr != errNone) rspNext.error = readErr;
        else                    rspNext.data  = elemValue;
      end
      opSize: begin
        if (writeErr != errNone) rspNext.error = writeErr;
        else                     rspNext.data  = dataT'(curSize);
      end
      opPush: begin
        if (writeErr != errNone) begin
          rspNext.error = writeErr;
        end else if (curSize == sizeT'(ARRAY_LENGTH)) begin
          rspNext.error = errFull;
        end else begin
          storeEn  = 1'b1;                          // Append after last
          storeIdx = indexT'(curSize);
          sizeEn   = 1'b1;
          sizeNext = curSize + sizeT'(1);
        end
      end
      opPop: begin
        if (writeErr != errNone) begin
          rspNext.error = writeErr;
        end else if (curSize == '0) begin
          rspNext.error = errEmpty;
        end else begin
          sizeEn       = 1'b1;
          sizeNext     = curSize - sizeT'(1);
          rspNext.data = elements[arr][lastIdx];    // Removed element
        end
      end
      opAdd: begin
        if (readErr != errNone) begin
          rspNext.error = readErr;
        end else begin
          storeEn      = 1'b1;
          storeData    = addSum;
          rspNext.data = addSum;
        end
      end
      opAlloc: begin
        if (freeTop != '0) begin                    // Reuse latest freed
          allocEn       = 1'b1;
          allocFromList = 1'b1;
        end else if (nextNew < (ADDRESS_BITS + 1)'(ARRAY_COUNT)) begin
          allocEn    = 1'b1;
          allocArray = arrayNumT'(nextNew);
        end else begin
          rspNext.error = errOutOfMemory;
        end
        if (allocEn) begin
          sizeEn       = 1'b1;                      // New array starts empty
          sizeArray    = allocArray;
          sizeNext     = '0;
          rspNext.data = dataT'(allocArray);
        end
      end
      opFree: begin
        if (writeErr != errNone) rspNext.error = writeErr;
        else                     freeEn        = 1'b1;
      end
      default: begin
        rspNext.error = errUnknownAction;
      end
    endcase
  end

  // Take the head only when idle
  assign popTake = (engState == engIdle) && headValid;
  assign rspReq  = (engState == engWaitAck);

  //------------------------------------------------------------
  // Handshake FSM and control state
  //------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      engState  <= engIdle;
      sizes     <= '0;
      allocated <= '0;
      everUsed  <= '0;
      nextNew   <= '0;
      freeTop   <= '0;
    end else begin
      case (engState)
        engIdle:        if (headValid) engState <= engWaitAck;
        engWaitAck:     if (rspAck)    engState <= engWaitRelease;
        engWaitRelease: if (!rspAck)   engState <= engIdle;
        default:                       engState <= engIdle;
      endcase
      if (popTake) begin
        if (sizeEn) begin
          sizes[sizeArray] <= sizeNext;
        end
        if (allocEn) begin
          allocated[allocArray] <= 1'b1;
          everUsed[allocArray]  <= 1'b1;
          if (allocFromList) freeTop <= freeTop - 1'b1;
          else               nextNew <= nextNew + 1'b1;
        end
        if (freeEn) begin
          allocated[arr] <= 1'b0;
          freeTop        <= freeTop + 1'b1;         // Push on free list
        end
      end
    end
  end

  // Element storage, free list slots and response word
  always_ff @(posedge clock) begin
    if (popTake && storeEn) begin
      elements[arr][storeIdx] <= storeData;
    end
    if (popTake && freeEn) begin
      freeList[arrayNumT'(freeTop)] <= arr;
    end
    if (popTake) begin
      response <= rspNext;                          // Held until next take
    end
  end

endmodule

// ==== hdl/heapCommandQueue.sv ====
// Heap command queue
// Circular buffer of decoded requests between the decoder and the engine

`timescale 1ns/1ps

module heapCommandQueue (
  input  logic              clock,
  input  logic              resetN,
  input  logic              pushValid,              // Write an entry
  input  heapPkg::requestT  pushRequest,            // Entry to write
  input  logic              popTake,                // Remove the head
  output logic              headValid,              // Head holds an entry
  output heapPkg::requestT  headRequest,            // Oldest entry
  output logic              queueFull               // No room left
);

  import heapPkg::*;

  typedef logic [$clog2(QUEUE_DEPTH)-1:0] ptrT;
  typedef logic [$clog2(QUEUE_DEPTH):0]   countT;

  requestT entries [QUEUE_DEPTH];                   // Entry storage
  ptrT     rdPtr;                                   // Head position
  ptrT     wrPtr;                                   // Next free slot
  countT   count;                                   // Entries held
  logic    doPush;
  logic    doPop;

  assign headValid   = (count != '0);
  assign queueFull   = (count == countT'(QUEUE_DEPTH));
  assign headRequest = entries[rdPtr];

  assign doPush = pushValid && !queueFull;          // Full queue takes no write
  assign doPop  = popTake && headValid;

  //------------------------------------------------------------
  // Pointers and count
  //------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= wrPtr + 1'b1;                      // Wraps at depth
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                    // Both or neither
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge clock) begin
    if (doPush) begin
      entries[wrPtr] <= pushRequest;
    end
  end

endmodule

// ==== hdl/heapCommandDecoder.sv ====
// Heap command decoder
// Request side of the four-phase handshake; turns the raw action byte
// into a kept operation and writes it into the command queue

`timescale 1ns/1ps

module heapCommandDecoder (
  input  logic              clock,
  input  logic              resetN,
  input  logic              cmdReq,                 // Request from requester
  input  heapPkg::commandT  command,                // Held stable while cmdReq high
  input  logic              queueFull,              // Queue cannot take a write
  output logic              cmdAck,                 // Command accepted
  output logic              pushValid,              // One-cycle queue write
  output heapPkg::requestT  pushRequest             // Decoded entry
);

  import heapPkg::*;

  typedef enum logic [1:0] {
    decIdle,                                        // Waiting for cmdReq
    decAck,                                         // Acknowledged, cmdReq still high
    decRelease                                      // cmdReq low, dropping cmdAck
  } decStateT;

  decStateT decState;
  opKindT   opKind;

  //------------------------------------------------------------
  // Action byte decode
  //------------------------------------------------------------
  always_comb begin
    case (command.action)
      ACTION_WRITE: opKind = opWrite;
      ACTION_READ:  opKind = opRead;
      ACTION_SIZE:  opKind = opSize;
      ACTION_PUSH:  opKind = opPush;
      ACTION_POP:   opKind = opPop;
      ACTION_ALLOC: opKind = opAlloc;
      ACTION_FREE:  opKind = opFree;
      ACTION_ADD:   opKind = opAdd;
      default:      opKind = opUnknown;             // Includes the old reset action
    endcase
  end

  always_comb begin
    pushRequest.opKind = opKind;
    pushRequest.array  = command.array;
    pushRequest.index  = command.index;
    pushRequest.data   = command.data;
  end

  // Write happens on the edge that moves us to decAck
  assign pushValid = (decState == decIdle) && cmdReq && !queueFull;

  //------------------------------------------------------------
  // Handshake FSM
  //------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      decState <= decIdle;
    end else begin
      case (decState)
        decIdle: begin
          if (pushValid) begin
            decState <= decAck;                     // Entry written this edge
          end
        end
        decAck: begin
          if (!cmdReq) begin
            decState <= decRelease;                 // Requester let go
          end
        end
        decRelease: begin
          decState <= decIdle;                      // cmdAck falls here
        end
        default: begin
          decState <= decIdle;
        end
      endcase
    end
  end

  assign cmdAck = (decState == decAck) || (decState == decRelease);

endmodule

// ==== hdl/heapPkg.sv ====
// Heap of fixed-length arrays
// Sizes, action codes, error codes and the command, request and response words

package heapPkg;

  //------------------------------------------------------------
  // Sizes
  //------------------------------------------------------------
  localparam int ADDRESS_BITS = 2;                      // Bits in an array number
  localparam int INDEX_BITS   = 2;                      // Bits in an element index
  localparam int DATA_BITS    = 12;                     // Bits in an element
  localparam int ARRAY_COUNT  = 2 ** ADDRESS_BITS;      // Arrays in the heap
  localparam int ARRAY_LENGTH = 2 ** INDEX_BITS;        // Elements per array
  localparam int QUEUE_DEPTH  = 4;                      // Command queue entries

  //------------------------------------------------------------
  // Action byte values on the request side
  //------------------------------------------------------------
  localparam logic [7:0] ACTION_WRITE = 8'd2;           // Write an element
  localparam logic [7:0] ACTION_READ  = 8'd3;           // Read an element
  localparam logic [7:0] ACTION_SIZE  = 8'd4;           // Size of an array
  localparam logic [7:0] ACTION_PUSH  = 8'd14;          // Append if room
  localparam logic [7:0] ACTION_POP   = 8'd15;          // Remove last if any
  localparam logic [7:0] ACTION_ALLOC = 8'd18;          // Hand out an array
  localparam logic [7:0] ACTION_FREE  = 8'd19;          // Give an array back
  localparam logic [7:0] ACTION_ADD   = 8'd20;          // Add, return new value

  typedef logic [ADDRESS_BITS-1:0] arrayNumT;           // Array number
  typedef logic [INDEX_BITS-1:0]   indexT;              // Element index
  typedef logic [DATA_BITS-1:0]    dataT;               // Element value
  typedef logic [INDEX_BITS:0]     sizeT;               // 0 to ARRAY_LENGTH

  typedef enum logic [3:0] {
    opWrite,
    opRead,
    opSize,
    opPush,
    opPop,
    opAlloc,
    opFree,
    opAdd,
    opUnknown                                           // Any unlisted action byte
  } opKindT;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,                                    // Never handed out
    errFreed,                                           // Handed out, then freed
    errOutOfBounds,                                     // Index not below size
    errFull,                                            // Push at full length
    errEmpty,                                           // Pop of empty array
    errOutOfMemory,                                     // No array left to allocate
    errUnknownAction
  } errorT;

  typedef struct packed {
    logic [7:0] action;                                 // Raw action byte
    arrayNumT   array;
    indexT      index;
    dataT       data;
  } commandT;                                           // External request word, 24 bits

  typedef struct packed {
    opKindT   opKind;                                   // Decoded action
    arrayNumT array;
    indexT    index;
    dataT     data;
  } requestT;                                           // Queue entry, 20 bits

  typedef struct packed {
    dataT  data;
    errorT error;
  } responseT;                                          // External response word, 15 bits

endpackage
